//--- hci_lite.f
source/hci_pkg.sv
source/hci_queue_if.sv
source/hci_csr_decode.sv
source/hci_csr_regs.sv
source/hci_queue.sv
source/hci_csr_response.sv
source/hci_top.sv
dv/tb_hci_top.sv

//--- Bender.yml
package:
  name: hci_lite

sources:
  - files:
      - source/hci_pkg.sv
      - source/hci_queue_if.sv
      - source/hci_csr_decode.sv
      - source/hci_csr_regs.sv
      - source/hci_queue.sv
      - source/hci_csr_response.sv
      - source/hci_top.sv
  - target: test
    files:
      - dv/tb_hci_top.sv

//--- dv/hci_input.txt
// op addr data err, all hex; 1 CPU write, 2 CPU read, 3 response push, 4 command pop
// 5 SETDASA and 6 RSTDAA (addr = virtual), 7 command burst, 8 response burst, F end
1 01C 00000302 0
2 01C 00000302 0
7 000 00000009 0
1 024 CAFE0001 0
4 000 CAFE0001 0
2 028 00000000 1
3 000 12345678 0
2 028 12345678 0
8 000 00000008 0
1 014 00000000 1
2 030 00000000 1
2 024 00000000 1
5 000 0000002A 0
2 014 8000002A 0
2 018 00000000 0
5 001 00000055 0
2 018 80000055 0
2 014 8000002A 0
6 000 00000000 0
2 014 00000000 0
2 018 80000055 0
1 024 00000011 0
1 024 00000022 0
3 000 000000AB 0
2 020 00000102 0
1 010 00000001 0
2 010 00000000 0
2 020 00020100 0
1 010 00000002 0
2 020 000A0000 0
F 000 00000000 0

//--- dv/tb_hci_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the HCI PIO top, driven by dv/hci_input.txt
// Queue and register models supply the expected status and burst data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module tb_hci_top;

  localparam logic [31:0] Seed         = 32'h8188_bfeb;
  localparam int          AckTimeout   = 4;
  localparam int          WaitTimeout  = 64;
  localparam int          DrainTimeout = 400;
  localparam int          RunTimeout   = 50000;  // Cycles
  localparam int          MaxRecords   = 64;

  logic               clk_i;
  logic               rst_ni;
  logic               csr_req_i;
  logic               csr_wr_i;
  hci_pkg::csr_addr_t csr_addr_i;
  hci_pkg::csr_data_t csr_wdata_i;
  logic               csr_ack_o;
  logic               csr_err_o;
  hci_pkg::csr_data_t csr_rdata_o;
  logic               cmd_rvalid_o;
  logic               cmd_rready_i;
  hci_pkg::csr_data_t cmd_rdata_o;
  logic               resp_wvalid_i;
  logic               resp_wready_o;
  hci_pkg::csr_data_t resp_wdata_i;
  logic               cmd_full_o;
  logic               cmd_empty_o;
  hci_pkg::depth_t    cmd_depth_o;
  logic               cmd_thld_trig_o;
  logic               resp_full_o;
  logic               resp_empty_o;
  hci_pkg::depth_t    resp_depth_o;
  logic               resp_thld_trig_o;
  hci_pkg::dev_addr_t set_dasa_i;
  logic               set_dasa_valid_i;
  logic               set_dasa_virtual_i;
  logic               rstdaa_i;

  // Reference model
  hci_pkg::csr_data_t cmd_model [$];
  hci_pkg::csr_data_t resp_model [$];
  hci_pkg::thld_t     cmd_thld_m;
  hci_pkg::thld_t     resp_thld_m;

  logic [31:0] rng_state;
  logic [31:0] stim_mem [MaxRecords*4];  // Four words per record

  hci_top dut_i (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .csr_req_i(csr_req_i), .csr_wr_i(csr_wr_i),
    .csr_addr_i(csr_addr_i), .csr_wdata_i(csr_wdata_i),
    .csr_ack_o(csr_ack_o), .csr_err_o(csr_err_o), .csr_rdata_o(csr_rdata_o),
    .cmd_rvalid_o(cmd_rvalid_o), .cmd_rready_i(cmd_rready_i), .cmd_rdata_o(cmd_rdata_o),
    .resp_wvalid_i(resp_wvalid_i), .resp_wready_o(resp_wready_o),
    .resp_wdata_i(resp_wdata_i),
    .cmd_full_o(cmd_full_o), .cmd_empty_o(cmd_empty_o), .cmd_depth_o(cmd_depth_o),
    .cmd_thld_trig_o(cmd_thld_trig_o),
    .resp_full_o(resp_full_o), .resp_empty_o(resp_empty_o), .resp_depth_o(resp_depth_o),
    .resp_thld_trig_o(resp_thld_trig_o),
    .set_dasa_i(set_dasa_i), .set_dasa_valid_i(set_dasa_valid_i),
    .set_dasa_virtual_i(set_dasa_virtual_i), .rstdaa_i(rstdaa_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    repeat (RunTimeout) @(posedge clk_i);
    report_failure("simulation did not finish in time");
  end

  task automatic finish_run(input logic failed);
    if (failed) begin
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first error");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%0t: %s", $time, msg);
    finish_run(1'b1);
  endtask

  task automatic check_data(input string what, input hci_pkg::csr_data_t act,
                            input hci_pkg::csr_data_t exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, act, exp);
      finish_run(1'b1);
    end
  endtask

  task automatic check_flag(input string what, input logic act, input logic exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, act, exp);
      finish_run(1'b1);
    end
  endtask

  task automatic check_depth(input string what, input hci_pkg::depth_t act,
                             input hci_pkg::depth_t exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, act, exp);
      finish_run(1'b1);
    end
  endtask

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic compare_status();
    int cmd_n;
    int resp_n;
    cmd_n  = cmd_model.size();
    resp_n = resp_model.size();
    check_depth("cmd_depth_o", cmd_depth_o, hci_pkg::depth_t'(cmd_n));
    check_flag("cmd_full_o", cmd_full_o, cmd_n == hci_pkg::CmdFifoDepth);
    check_flag("cmd_empty_o", cmd_empty_o, cmd_n == 0);
    check_flag("cmd_rvalid_o", cmd_rvalid_o, cmd_n != 0);
    // Free entries against the command threshold
    check_flag("cmd_thld_trig_o", cmd_thld_trig_o,
               (hci_pkg::CmdFifoDepth - cmd_n) >= int'(cmd_thld_m));
    check_depth("resp_depth_o", resp_depth_o, hci_pkg::depth_t'(resp_n));
    check_flag("resp_full_o", resp_full_o, resp_n == hci_pkg::RespFifoDepth);
    check_flag("resp_empty_o", resp_empty_o, resp_n == 0);
    check_flag("resp_wready_o", resp_wready_o, resp_n != hci_pkg::RespFifoDepth);
    check_flag("resp_thld_trig_o", resp_thld_trig_o,
               (resp_thld_m != '0) && (resp_n >= int'(resp_thld_m)));
  endtask

  task automatic check_status();
    @(posedge clk_i);
    @(negedge clk_i);
    compare_status();
  endtask

  task automatic apply_write(input hci_pkg::csr_addr_t addr, input hci_pkg::csr_data_t data);
    case (addr)
      hci_pkg::AddrQueueThld: begin
        cmd_thld_m  = data[7:0];
        resp_thld_m = data[15:8];
      end
      hci_pkg::AddrCommandPort: begin
        if (cmd_model.size() < hci_pkg::CmdFifoDepth) begin
          cmd_model.push_back(data);
        end
      end
      hci_pkg::AddrResetCtrl: begin
        if (data[0]) begin
          cmd_model.delete();
        end
        if (data[1]) begin
          resp_model.delete();
        end
      end
      default: ;
    endcase
  endtask

  // Single request with its ack exactly one cycle later
  task automatic csr_access(input logic wr, input hci_pkg::csr_addr_t addr,
                            input hci_pkg::csr_data_t wdata,
                            output hci_pkg::csr_data_t rdata, output logic err);
    int waited;
    @(posedge clk_i);
    csr_req_i   <= 1'b1;
    csr_wr_i    <= wr;
    csr_addr_i  <= addr;
    csr_wdata_i <= wdata;
    @(negedge clk_i);
    check_flag("csr_ack_o in request cycle", csr_ack_o, 1'b0);
    @(posedge clk_i);
    csr_req_i <= 1'b0;
    waited = 1;
    @(negedge clk_i);
    while (!csr_ack_o && waited < AckTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (!csr_ack_o) begin
      report_failure("CPU request was never acknowledged");
    end
    if (waited != 1) begin
      report_failure("CPU request was acknowledged late");
    end
    rdata = csr_rdata_o;
    err   = csr_err_o;
  endtask

  task automatic check_ack(input logic exp_err);
    check_flag("csr_ack_o", csr_ack_o, 1'b1);
    check_flag("csr_err_o", csr_err_o, exp_err);
    check_data("csr_rdata_o on a write", csr_rdata_o, '0);
  endtask

  // Back-to-back writes at one request per cycle
  task automatic write_command_burst(input int count);
    logic               exp_err [$];
    hci_pkg::csr_data_t word;
    int                 i;
    for (i = 0; i < count; i++) begin
      word = next_rand();
      @(posedge clk_i);
      csr_req_i   <= 1'b1;
      csr_wr_i    <= 1'b1;
      csr_addr_i  <= hci_pkg::AddrCommandPort;
      csr_wdata_i <= word;
      if (cmd_model.size() < hci_pkg::CmdFifoDepth) begin
        cmd_model.push_back(word);
        exp_err.push_back(1'b0);
      end else begin
        exp_err.push_back(1'b1);  // Queue full so the word is dropped
      end
      @(negedge clk_i);
      if (i == 0) begin
        check_flag("csr_ack_o before first ack", csr_ack_o, 1'b0);
      end else begin
        check_ack(exp_err.pop_front());
      end
    end
    @(posedge clk_i);
    csr_req_i <= 1'b0;
    @(negedge clk_i);
    check_ack(exp_err.pop_front());
  endtask

  task automatic drain_commands();
    logic [31:0] r;
    int          cycles;
    cycles = 0;
    while (cmd_model.size() != 0) begin
      if (cycles >= DrainTimeout) begin
        report_failure("command queue did not drain");
      end
      r = next_rand();
      @(posedge clk_i);
      cmd_rready_i <= r[0];  // Random stall
      @(negedge clk_i);
      compare_status();
      if (cmd_rready_i) begin
        check_data("cmd_rdata_o", cmd_rdata_o, cmd_model.pop_front());
      end
      cycles++;
    end
    @(posedge clk_i);
    cmd_rready_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic pop_command(input hci_pkg::csr_data_t exp);
    hci_pkg::csr_data_t head;
    int                 waited;
    waited = 0;
    @(negedge clk_i);
    while (!cmd_rvalid_o && waited < WaitTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (!cmd_rvalid_o) begin
      report_failure("cmd_rvalid_o never went high");
    end
    @(posedge clk_i);
    cmd_rready_i <= 1'b1;
    @(negedge clk_i);
    head = cmd_model.pop_front();
    check_data("popped command word", cmd_rdata_o, exp);
    check_data("popped command word against model", cmd_rdata_o, head);
    @(posedge clk_i);
    cmd_rready_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic push_response(input hci_pkg::csr_data_t data);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!resp_wready_o && waited < WaitTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (!resp_wready_o) begin
      report_failure("resp_wready_o never went high");
    end
    @(posedge clk_i);
    resp_wvalid_i <= 1'b1;
    resp_wdata_i  <= data;
    @(posedge clk_i);
    resp_wvalid_i <= 1'b0;
    resp_model.push_back(data);
    @(negedge clk_i);
  endtask

  task automatic response_burst(input int count);
    hci_pkg::csr_data_t rdata;
    logic               err;
    int                 i;
    for (i = 0; i < count; i++) begin
      push_response(next_rand());
    end
    compare_status();  // Loaded queue
    while (resp_model.size() != 0) begin
      csr_access(1'b0, hci_pkg::AddrResponsePort, '0, rdata, err);
      check_flag("csr_err_o on response read", err, 1'b0);
      check_data("response word", rdata, resp_model.pop_front());
      compare_status();
    end
  endtask

  task automatic address_update(input logic virt, input hci_pkg::dev_addr_t addr,
                                input logic clear);
    @(posedge clk_i);
    set_dasa_i         <= addr;
    set_dasa_valid_i   <= !clear;
    set_dasa_virtual_i <= virt;
    rstdaa_i           <= clear;
    @(posedge clk_i);
    set_dasa_valid_i <= 1'b0;
    rstdaa_i         <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic run_stimulus();
    logic [31:0]        op;
    logic [31:0]        arg;
    hci_pkg::csr_data_t data;
    logic               exp_err;
    hci_pkg::csr_data_t rdata;
    logic               err;
    int                 rec;
    logic               done;
    rec  = 0;
    done = 1'b0;
    while (!done) begin
      if (rec >= MaxRecords) begin
        report_failure("stimulus file has no end record");
      end
      op      = stim_mem[rec*4];
      arg     = stim_mem[rec*4+1];
      data    = stim_mem[rec*4+2];
      exp_err = stim_mem[rec*4+3][0];
      case (op)
        32'h1: begin
          csr_access(1'b1, arg[11:0], data, rdata, err);
          check_flag("csr_err_o on write", err, exp_err);
          check_data("csr_rdata_o on write", rdata, '0);
          apply_write(arg[11:0], data);
        end
        32'h2: begin
          csr_access(1'b0, arg[11:0], '0, rdata, err);
          check_flag("csr_err_o on read", err, exp_err);
          check_data("csr_rdata_o on read", rdata, data);
          if (arg[11:0] == hci_pkg::AddrResponsePort && resp_model.size() != 0) begin
            check_data("response word against model", rdata, resp_model.pop_front());
          end
        end
        32'h3: push_response(data);
        32'h4: pop_command(data);
        32'h5: address_update(arg[0], data[6:0], 1'b0);
        32'h6: address_update(arg[0], '0, 1'b1);
        32'h7: begin
          write_command_burst(data);
          check_status();
          drain_commands();
        end
        32'h8: response_burst(data);
        32'hF: done = 1'b1;
        default: report_failure("unknown or missing opcode in stimulus file");
      endcase
      check_status();
      rec++;
    end
  endtask

  initial begin
    rng_state          = Seed;
    rst_ni             = 1'b0;
    csr_req_i          = 1'b0;
    csr_wr_i           = 1'b0;
    csr_addr_i         = '0;
    csr_wdata_i        = '0;
    cmd_rready_i       = 1'b0;
    resp_wvalid_i      = 1'b0;
    resp_wdata_i       = '0;
    set_dasa_i         = '0;
    set_dasa_valid_i   = 1'b0;
    set_dasa_virtual_i = 1'b0;
    rstdaa_i           = 1'b0;
    cmd_thld_m         = '0;
    resp_thld_m        = '0;
    $readmemh("dv/hci_input.txt", stim_mem);
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_flag("csr_ack_o after reset", csr_ack_o, 1'b0);
    check_flag("csr_err_o after reset", csr_err_o, 1'b0);
    compare_status();
    run_stimulus();
    finish_run(1'b0);
  end

endmodule

`default_nettype wire

//--- source/hci_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI PIO top: CPU register port, command and response queues, address regs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module hci_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               csr_req_i,
  input  logic               csr_wr_i,
  input  hci_pkg::csr_addr_t csr_addr_i,
  input  hci_pkg::csr_data_t csr_wdata_i,
  output logic               csr_ack_o,
  output logic               csr_err_o,
  output hci_pkg::csr_data_t csr_rdata_o,
  output logic               cmd_rvalid_o,
  input  logic               cmd_rready_i,
  output hci_pkg::csr_data_t cmd_rdata_o,
  input  logic               resp_wvalid_i,
  output logic               resp_wready_o,
  input  hci_pkg::csr_data_t resp_wdata_i,
  output logic               cmd_full_o,
  output logic               cmd_empty_o,
  output hci_pkg::depth_t    cmd_depth_o,
  output logic               cmd_thld_trig_o,
  output logic               resp_full_o,
  output logic               resp_empty_o,
  output hci_pkg::depth_t    resp_depth_o,
  output logic               resp_thld_trig_o,
  input  hci_pkg::dev_addr_t set_dasa_i,
  input  logic               set_dasa_valid_i,
  input  logic               set_dasa_virtual_i,
  input  logic               rstdaa_i
);

  hci_queue_if cmd_q ();
  hci_queue_if resp_q ();
  hci_regs_if  regs ();

  logic                 reg_we;
  hci_pkg::csr_target_e reg_target;
  hci_pkg::csr_data_t   reg_wdata;
  logic                 rsp_valid;
  logic                 rsp_err;
  hci_pkg::csr_target_e rsp_target;

  // Queues gate the controller pop on empty and push on full
  assign cmd_q.pop     = cmd_rready_i;
  assign cmd_rvalid_o  = !cmd_q.empty;
  assign cmd_rdata_o   = cmd_q.rdata;
  assign resp_q.push   = resp_wvalid_i;
  assign resp_q.wdata  = resp_wdata_i;
  assign resp_wready_o = !resp_q.full;

  assign cmd_full_o   = cmd_q.full;
  assign cmd_empty_o  = cmd_q.empty;
  assign cmd_depth_o  = cmd_q.depth;
  assign resp_full_o  = resp_q.full;
  assign resp_empty_o = resp_q.empty;
  assign resp_depth_o = resp_q.depth;

  hci_csr_decode u_decode (
    .clk_i, .rst_ni, .csr_req_i, .csr_wr_i, .csr_addr_i, .csr_wdata_i,
    .cmd_q, .resp_q,
    .reg_we_o(reg_we), .reg_target_o(reg_target), .reg_wdata_o(reg_wdata),
    .rsp_valid_o(rsp_valid), .rsp_err_o(rsp_err), .rsp_target_o(rsp_target)
  );

  hci_csr_regs u_regs (
    .clk_i, .rst_ni,
    .reg_we_i(reg_we), .reg_target_i(reg_target), .reg_wdata_i(reg_wdata),
    .set_dasa_i, .set_dasa_valid_i, .set_dasa_virtual_i, .rstdaa_i,
    .cmd_q, .resp_q, .regs
  );

  hci_queue #(.Depth(hci_pkg::CmdFifoDepth)) u_cmd_queue (
    .clk_i, .rst_ni, .q(cmd_q), .thld_i(regs.cmd_thld),
    .count_free_i(1'b1), .thld_trig_o(cmd_thld_trig_o)
  );

  hci_queue #(.Depth(hci_pkg::RespFifoDepth)) u_resp_queue (
    .clk_i, .rst_ni, .q(resp_q), .thld_i(regs.resp_thld),
    .count_free_i(1'b0), .thld_trig_o(resp_thld_trig_o)
  );

  hci_csr_response u_response (
    .clk_i, .rst_ni,
    .rsp_valid_i(rsp_valid), .rsp_err_i(rsp_err), .rsp_target_i(rsp_target),
    .resp_q, .cmd_q, .regs,
    .csr_ack_o, .csr_err_o, .csr_rdata_o
  );

endmodule

`default_nettype wire

//--- source/hci_csr_response.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU read data, ack and error, one cycle after the request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module hci_csr_response (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rsp_valid_i,
  input  logic                 rsp_err_i,
  input  hci_pkg::csr_target_e rsp_target_i,
  hci_queue_if.view            resp_q,
  hci_queue_if.view            cmd_q,
  hci_regs_if.view             regs,
  output logic                 csr_ack_o,
  output logic                 csr_err_o,
  output hci_pkg::csr_data_t   csr_rdata_o
);

  hci_pkg::csr_data_t resp_word_q;
  hci_pkg::csr_data_t rd_value;

  // Head word as it stood in the request cycle, i.e. the popped word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_word_q <= '0;
    end else begin
      resp_word_q <= resp_q.rdata;
    end
  end

  always_comb begin
    rd_value = '0;
    case (rsp_target_i)
      hci_pkg::TgtResetCtrl: begin
        rd_value[hci_pkg::RstCmdBit]  = regs.cmd_rst;
        rd_value[hci_pkg::RstRespBit] = regs.resp_rst;
      end
      hci_pkg::TgtDevAddr: begin
        rd_value[hci_pkg::DevAddrValidBit]                 = regs.dev_valid;
        rd_value[hci_pkg::DevAddrLsb +: hci_pkg::DevAddrW] = regs.dev_addr;
      end
      hci_pkg::TgtVirtDevAddr: begin
        rd_value[hci_pkg::DevAddrValidBit]                 = regs.virt_valid;
        rd_value[hci_pkg::DevAddrLsb +: hci_pkg::DevAddrW] = regs.virt_addr;
      end
      hci_pkg::TgtThld: begin
        rd_value[hci_pkg::ThldCmdLsb +: hci_pkg::ThldW]  = regs.cmd_thld;
        rd_value[hci_pkg::ThldRespLsb +: hci_pkg::ThldW] = regs.resp_thld;
      end
      hci_pkg::TgtStatus: begin
        rd_value[hci_pkg::StatCmdDepthLsb +: hci_pkg::DepthW]  = cmd_q.depth;
        rd_value[hci_pkg::StatRespDepthLsb +: hci_pkg::DepthW] = resp_q.depth;
        rd_value[hci_pkg::StatCmdFullBit]   = cmd_q.full;
        rd_value[hci_pkg::StatCmdEmptyBit]  = cmd_q.empty;
        rd_value[hci_pkg::StatRespFullBit]  = resp_q.full;
        rd_value[hci_pkg::StatRespEmptyBit] = resp_q.empty;
      end
      hci_pkg::TgtRespPort: rd_value = resp_word_q;
      default:              rd_value = '0;  // Writes and unmapped
    endcase
  end

  assign csr_ack_o   = rsp_valid_i;
  assign csr_err_o   = rsp_valid_i && rsp_err_i;
  assign csr_rdata_o = (rsp_valid_i && !rsp_err_i) ? rd_value : '0;

endmodule

`default_nettype wire

//--- source/hci_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular FIFO with flush, occupancy count and threshold trigger
// Serves as both the command and the response queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module hci_queue #(
  parameter int unsigned Depth = 8
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  hci_queue_if.queue     q,
  input  hci_pkg::thld_t thld_i,
  input  logic           count_free_i,
  output logic           thld_trig_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam logic [PtrW-1:0] LastPtr = PtrW'(Depth - 1);

  hci_pkg::csr_data_t mem [Depth];
  logic [PtrW-1:0]    wr_ptr_q;
  logic [PtrW-1:0]    rd_ptr_q;
  hci_pkg::depth_t    count_q;
  hci_pkg::depth_t    free_entries;
  logic               push_ok;
  logic               pop_ok;

  assign q.full  = (count_q == hci_pkg::depth_t'(Depth));
  assign q.empty = (count_q == '0);
  assign q.depth = count_q;
  assign q.rdata = mem[rd_ptr_q];

  // Flush beats both sides
  assign push_ok = q.push && !q.full && !q.flush;
  assign pop_ok  = q.pop && !q.empty && !q.flush;

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= q.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (q.flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign free_entries = hci_pkg::depth_t'(Depth) - count_q;

  // Command side counts room, response side counts fill
  always_comb begin
    if (count_free_i) begin
      thld_trig_o = (hci_pkg::thld_t'(free_entries) >= thld_i);
    end else begin
      thld_trig_o = (thld_i != '0) && (hci_pkg::thld_t'(count_q) >= thld_i);
    end
  end

endmodule

`default_nettype wire

//--- source/hci_csr_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RESET_CONTROL, QUEUE_THLD and the real and virtual dynamic address regs
// Reset bits drive the queue flushes and clear themselves after one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module hci_csr_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 reg_we_i,
  input  hci_pkg::csr_target_e reg_target_i,
  input  hci_pkg::csr_data_t   reg_wdata_i,
  input  hci_pkg::dev_addr_t   set_dasa_i,
  input  logic                 set_dasa_valid_i,
  input  logic                 set_dasa_virtual_i,
  input  logic                 rstdaa_i,
  hci_queue_if.ctrl            cmd_q,
  hci_queue_if.ctrl            resp_q,
  hci_regs_if.regs             regs
);

  logic               rst_ctrl_we;
  logic               thld_we;
  logic               addr_upd;
  logic               cmd_rst_q;
  logic               resp_rst_q;
  hci_pkg::thld_t     cmd_thld_q;
  hci_pkg::thld_t     resp_thld_q;
  hci_pkg::dev_addr_t dev_addr_q;
  logic               dev_valid_q;
  hci_pkg::dev_addr_t virt_addr_q;
  logic               virt_valid_q;

  assign rst_ctrl_we = reg_we_i && (reg_target_i == hci_pkg::TgtResetCtrl);
  assign thld_we     = reg_we_i && (reg_target_i == hci_pkg::TgtThld);
  assign addr_upd    = set_dasa_valid_i || rstdaa_i;

  // High for exactly the cycle after the write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_rst_q  <= 1'b0;
      resp_rst_q <= 1'b0;
    end else begin
      cmd_rst_q  <= rst_ctrl_we && reg_wdata_i[hci_pkg::RstCmdBit];
      resp_rst_q <= rst_ctrl_we && reg_wdata_i[hci_pkg::RstRespBit];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_thld_q  <= '0;
      resp_thld_q <= '0;
    end else if (thld_we) begin
      cmd_thld_q  <= reg_wdata_i[hci_pkg::ThldCmdLsb +: hci_pkg::ThldW];
      resp_thld_q <= reg_wdata_i[hci_pkg::ThldRespLsb +: hci_pkg::ThldW];
    end
  end

  // RSTDAA wins over SETDASA on the selected device
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dev_addr_q   <= '0;
      dev_valid_q  <= 1'b0;
      virt_addr_q  <= '0;
      virt_valid_q <= 1'b0;
    end else if (addr_upd) begin
      if (set_dasa_virtual_i) begin
        virt_valid_q <= !rstdaa_i;
        virt_addr_q  <= rstdaa_i ? '0 : set_dasa_i;
      end else begin
        dev_valid_q <= !rstdaa_i;
        dev_addr_q  <= rstdaa_i ? '0 : set_dasa_i;
      end
    end
  end

  assign cmd_q.flush  = cmd_rst_q;
  assign resp_q.flush = resp_rst_q;

  assign regs.cmd_rst    = cmd_rst_q;
  assign regs.resp_rst   = resp_rst_q;
  assign regs.cmd_thld   = cmd_thld_q;
  assign regs.resp_thld  = resp_thld_q;
  assign regs.dev_addr   = dev_addr_q;
  assign regs.dev_valid  = dev_valid_q;
  assign regs.virt_addr  = virt_addr_q;
  assign regs.virt_valid = virt_valid_q;

endmodule

`default_nettype wire

//--- source/hci_csr_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU request decode: register strobes, queue push/pop and access errors
// Target and error are registered here and consumed by the response stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module hci_csr_decode (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 csr_req_i,
  input  logic                 csr_wr_i,
  input  hci_pkg::csr_addr_t   csr_addr_i,
  input  hci_pkg::csr_data_t   csr_wdata_i,
  hci_queue_if.ctrl            cmd_q,
  hci_queue_if.ctrl            resp_q,
  output logic                 reg_we_o,
  output hci_pkg::csr_target_e reg_target_o,
  output hci_pkg::csr_data_t   reg_wdata_o,
  output logic                 rsp_valid_o,
  output logic                 rsp_err_o,
  output hci_pkg::csr_target_e rsp_target_o
);

  hci_pkg::csr_target_e target;
  logic                 access_err;

  always_comb begin
    case (csr_addr_i)
      hci_pkg::AddrResetCtrl:    target = hci_pkg::TgtResetCtrl;
      hci_pkg::AddrDevAddr:      target = hci_pkg::TgtDevAddr;
      hci_pkg::AddrVirtDevAddr:  target = hci_pkg::TgtVirtDevAddr;
      hci_pkg::AddrQueueThld:    target = hci_pkg::TgtThld;
      hci_pkg::AddrQueueStatus:  target = hci_pkg::TgtStatus;
      hci_pkg::AddrCommandPort:  target = hci_pkg::TgtCmdPort;
      hci_pkg::AddrResponsePort: target = hci_pkg::TgtRespPort;
      default:                   target = hci_pkg::TgtNone;
    endcase
  end

  // Illegal direction, unmapped, or a port that can't take the access
  always_comb begin
    case (target)
      hci_pkg::TgtNone:        access_err = 1'b1;
      hci_pkg::TgtDevAddr,
      hci_pkg::TgtVirtDevAddr,
      hci_pkg::TgtStatus:      access_err = csr_wr_i;
      hci_pkg::TgtCmdPort:     access_err = !csr_wr_i || cmd_q.full;
      hci_pkg::TgtRespPort:    access_err = csr_wr_i || resp_q.empty;
      default:                 access_err = 1'b0;
    endcase
  end

  assign cmd_q.push  = csr_req_i && csr_wr_i && !access_err &&
                       (target == hci_pkg::TgtCmdPort);
  assign cmd_q.wdata = csr_wdata_i;
  assign resp_q.pop  = csr_req_i && !csr_wr_i && !access_err &&
                       (target == hci_pkg::TgtRespPort);

  assign reg_we_o     = csr_req_i && csr_wr_i && !access_err;  // Regs pick by target
  assign reg_target_o = target;
  assign reg_wdata_o  = csr_wdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o  <= 1'b0;
      rsp_err_o    <= 1'b0;
      rsp_target_o <= hci_pkg::TgtNone;
    end else begin
      rsp_valid_o  <= csr_req_i;
      rsp_err_o    <= csr_req_i && access_err;
      // Writes carry no target so they read back zero
      rsp_target_o <= (csr_req_i && !csr_wr_i) ? target : hci_pkg::TgtNone;
    end
  end

endmodule

`default_nettype wire

//--- source/hci_queue_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Queue and register bundles passed between the CSR blocks and the FIFOs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

interface hci_queue_if;
  logic               push;
  logic               pop;
  hci_pkg::csr_data_t wdata;
  hci_pkg::csr_data_t rdata;
  logic               full;
  logic               empty;
  hci_pkg::depth_t    depth;
  logic               flush;

  modport queue (input push, pop, wdata, flush, output rdata, full, empty, depth);
  modport ctrl  (output push, pop, wdata, flush, input full, empty);
  modport view  (input rdata, full, empty, depth);
endinterface

// Register values seen by the read path and the queues
interface hci_regs_if;
  logic               cmd_rst;
  logic               resp_rst;
  hci_pkg::thld_t     cmd_thld;
  hci_pkg::thld_t     resp_thld;
  hci_pkg::dev_addr_t dev_addr;
  logic               dev_valid;
  hci_pkg::dev_addr_t virt_addr;
  logic               virt_valid;

  modport regs (output cmd_rst, resp_rst, cmd_thld, resp_thld,
                output dev_addr, dev_valid, virt_addr, virt_valid);
  modport view (input cmd_rst, resp_rst, cmd_thld, resp_thld,
                input dev_addr, dev_valid, virt_addr, virt_valid);
endinterface

`default_nettype wire

//--- source/hci_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, CSR address map and field layout of the HCI PIO block
// Every RTL file refers to these by scoped names
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package hci_pkg;

  localparam int unsigned CsrAddrW = 12;
  localparam int unsigned CsrDataW = 32;
  localparam int unsigned DevAddrW = 7;
  localparam int unsigned ThldW    = 8;

  localparam int unsigned CmdFifoDepth  = 8;
  localparam int unsigned RespFifoDepth = 8;
  // Must hold the larger depth itself, not just depth-1
  localparam int unsigned DepthW =
      $clog2((CmdFifoDepth > RespFifoDepth ? CmdFifoDepth : RespFifoDepth) + 1);

  typedef logic [CsrAddrW-1:0] csr_addr_t;
  typedef logic [CsrDataW-1:0] csr_data_t;
  typedef logic [DevAddrW-1:0] dev_addr_t;
  typedef logic [ThldW-1:0]    thld_t;
  typedef logic [DepthW-1:0]   depth_t;

  localparam csr_addr_t AddrResetCtrl    = 12'h010;
  localparam csr_addr_t AddrDevAddr      = 12'h014;
  localparam csr_addr_t AddrVirtDevAddr  = 12'h018;
  localparam csr_addr_t AddrQueueThld    = 12'h01C;
  localparam csr_addr_t AddrQueueStatus  = 12'h020;
  localparam csr_addr_t AddrCommandPort  = 12'h024;
  localparam csr_addr_t AddrResponsePort = 12'h028;

  localparam int unsigned RstCmdBit       = 0;  // RESET_CONTROL
  localparam int unsigned RstRespBit      = 1;
  localparam int unsigned ThldCmdLsb      = 0;  // QUEUE_THLD
  localparam int unsigned ThldRespLsb     = 8;
  localparam int unsigned DevAddrLsb      = 0;  // Both device address regs
  localparam int unsigned DevAddrValidBit = 31;

  // QUEUE_STATUS
  localparam int unsigned StatCmdDepthLsb  = 0;
  localparam int unsigned StatRespDepthLsb = 8;
  localparam int unsigned StatCmdFullBit   = 16;
  localparam int unsigned StatCmdEmptyBit  = 17;
  localparam int unsigned StatRespFullBit  = 18;
  localparam int unsigned StatRespEmptyBit = 19;

  typedef enum logic [2:0] {
    TgtNone,
    TgtResetCtrl,
    TgtDevAddr,
    TgtVirtDevAddr,
    TgtThld,
    TgtStatus,
    TgtCmdPort,
    TgtRespPort
  } csr_target_e;

endpackage

`default_nettype wire
